// File: hdl/tpuIssuePkg.sv
/*
 * Tensor-processor issue stage, shared definitions
 * Table sizes, pipe latencies, instruction word layout and operand types
 */
package tpuIssuePkg;

	localparam int DEPTH_BUFF = 8;
	localparam int WIDTH_BUFF = 3;
	localparam int LAT_SCALAR = 2;
	localparam int LAT_VECTOR = 4;

	// Raw instruction word as fetched
	typedef struct packed {
		logic       isVec;     // 31
		logic       dstValid;  // 30
		logic       src1Valid; // 29
		logic       src2Valid; // 28
		logic       src3Valid; // 27
		logic [1:0] spare;     // 26:25
		logic [4:0] dst;       // 24:20
		logic [4:0] src1;      // 19:15
		logic [4:0] src2;      // 14:10
		logic [4:0] src3;      // 9:5
		logic [4:0] ignored;   // 4:0
	} instrWord_t;

	// Bank bit above the register number
	typedef logic [5:0] regIndex_t;

	typedef struct packed {
		logic      valid;
		regIndex_t idx;
	} operand_t;

	typedef struct packed {
		logic     isVec;
		operand_t dst;
		operand_t src1;
		operand_t src2;
		operand_t src3;
	} decoded_t;

	typedef logic [WIDTH_BUFF-1:0] issueNo_t;

endpackage

// File: hdl/decodedIf.sv
/*
 * Decoded instruction channel
 * Valid/ready handshake from decode into the hazard checker
 */
`timescale 1ns/100ps

interface decodedIf;

	logic                  valid;
	logic                  ready;
	tpuIssuePkg::decoded_t instr;

	modport source (
		output valid,
		output instr,
		input  ready
	);

	modport sink (
		input  valid,
		input  instr,
		output ready
	);

endinterface

// File: hdl/instrDecode.sv
/*
 * Instruction decode
 * One-entry holding register, splits a word into banked operand indices
 */
`timescale 1ns/100ps

module instrDecode (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    instrValid,
	input  tpuIssuePkg::instrWord_t instrWord,
	output logic                    instrReady,
	decodedIf.source                dec
);

	logic                  full;
	tpuIssuePkg::decoded_t decNext;

	function automatic tpuIssuePkg::operand_t makeOperand(input logic valid, input logic isVec,
			input logic [4:0] num);
		tpuIssuePkg::operand_t op;
		op.valid = valid;
		op.idx   = {isVec, num}; // Scalar and vector banks kept apart
		return op;
	endfunction

	always_comb begin
		decNext.isVec = instrWord.isVec;
		decNext.dst   = makeOperand(instrWord.dstValid, instrWord.isVec, instrWord.dst);
		decNext.src1  = makeOperand(instrWord.src1Valid, instrWord.isVec, instrWord.src1);
		decNext.src2  = makeOperand(instrWord.src2Valid, instrWord.isVec, instrWord.src2);
		decNext.src3  = makeOperand(instrWord.src3Valid, instrWord.isVec, instrWord.src3);
	end

	assign instrReady = ~full | dec.ready; // Empty or draining this cycle
	assign dec.valid  = full;

	always_ff @(posedge clock) begin
		if (reset) begin
			full <= 1'b0;
		end else if (instrValid && instrReady) begin
			full <= 1'b1;
		end else if (dec.ready) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (instrValid && instrReady) begin
			dec.instr <= decNext;
		end
	end

	holdWhileStalled: assert property (@(posedge clock) disable iff (reset)
		dec.valid && !dec.ready |=> dec.valid && $stable(dec.instr));

endmodule

// File: hdl/ringBuffCtrl.sv
/*
 * Ring buffer control for the instruction table
 * Allocation and issue pointers, occupancy and unissued counts
 */
`timescale 1ns/100ps

module ringBuffCtrl (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  alloc,
	input  logic                  issue,
	input  logic                  retire,
	output tpuIssuePkg::issueNo_t allocNo,
	output tpuIssuePkg::issueNo_t issueNo,
	output logic                  full,
	output logic                  pending
);

	logic [tpuIssuePkg::WIDTH_BUFF:0] occupancy;
	logic [tpuIssuePkg::WIDTH_BUFF:0] unissued;

	assign full    = occupancy == (tpuIssuePkg::WIDTH_BUFF+1)'(tpuIssuePkg::DEPTH_BUFF);
	assign pending = unissued != '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			allocNo   <= '0;
			issueNo   <= '0;
			occupancy <= '0;
			unissued  <= '0;
		end else begin
			if (alloc) allocNo <= allocNo + 1'b1; // Wraps at DEPTH_BUFF
			if (issue) issueNo <= issueNo + 1'b1;

			case ({alloc, retire})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase

			case ({alloc, issue})
				2'b10:   unissued <= unissued + 1'b1;
				2'b01:   unissued <= unissued - 1'b1;
				default: unissued <= unissued;
			endcase
		end
	end

	noAllocWhenFull: assert property (@(posedge clock) disable iff (reset) alloc |-> !full);
	noIssueWhenEmpty: assert property (@(posedge clock) disable iff (reset) issue |-> pending);

endmodule

// File: hdl/hazardCheck.sv
/*
 * Hazard checker
 * Holds accepted instructions, detects RAW/WAR/WAW against in-flight
 * entries, reserves write-back slots and issues in program order
 */
`timescale 1ns/100ps

module hazardCheck (
	input  logic                  clock,
	input  logic                  reset,
	decodedIf.sink                dec,
	input  logic                  complValid,
	input  tpuIssuePkg::issueNo_t complNo,
	input  logic                  retire,
	output logic                  issueValid,
	output tpuIssuePkg::issueNo_t issueNo,
	output logic                  issueIsVec,
	output logic                  rawHazard,
	output logic                  warHazard,
	output logic                  wawHazard
);

	tpuIssuePkg::decoded_t entryTab [tpuIssuePkg::DEPTH_BUFF];
	logic [tpuIssuePkg::DEPTH_BUFF-1:0] busy; // Issued, not yet completed

	tpuIssuePkg::decoded_t head;
	tpuIssuePkg::issueNo_t allocNo;
	tpuIssuePkg::issueNo_t headNo;
	logic                  full;
	logic                  pending;
	logic                  alloc;
	logic                  raw;
	logic                  war;
	logic                  waw;
	logic                  slotFree;
	logic                  issueGo;

	logic [tpuIssuePkg::LAT_VECTOR-1:0] wbSlot; // Bit k: completion k+1 cycles ahead
	logic [tpuIssuePkg::LAT_VECTOR-1:0] slotMask;

	function automatic logic sameReg(input tpuIssuePkg::operand_t a,
			input tpuIssuePkg::operand_t b);
		return a.valid & b.valid & (a.idx == b.idx);
	endfunction

	assign dec.ready = ~full;
	assign alloc     = dec.valid & ~full;
	assign head      = entryTab[headNo];

	////////////////////////////////////////
	// Hazard detection on the head entry
	always_comb begin
		raw = 1'b0;
		war = 1'b0;
		waw = 1'b0;
		for (int i = 0; i < tpuIssuePkg::DEPTH_BUFF; i++) begin
			if (busy[i]) begin
				raw |= sameReg(head.src1, entryTab[i].dst) | sameReg(head.src2, entryTab[i].dst)
					| sameReg(head.src3, entryTab[i].dst);
				war |= sameReg(head.dst, entryTab[i].src1) | sameReg(head.dst, entryTab[i].src2)
					| sameReg(head.dst, entryTab[i].src3);
				waw |= sameReg(head.dst, entryTab[i].dst);
			end
		end
	end

	// Completion lands 1+latency cycles after the decision
	// Nothing reserved earlier lands as late as a vector
	assign slotFree = head.isVec | ~wbSlot[tpuIssuePkg::LAT_SCALAR];
	assign slotMask = head.isVec
		? ((tpuIssuePkg::LAT_VECTOR)'(1) << (tpuIssuePkg::LAT_VECTOR - 1))
		: ((tpuIssuePkg::LAT_VECTOR)'(1) << (tpuIssuePkg::LAT_SCALAR - 1));

	assign issueGo = pending & ~(raw | war | waw) & slotFree;

	////////////////////////////////////////
	// Table and state
	always_ff @(posedge clock) begin
		if (alloc) entryTab[allocNo] <= dec.instr;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy   <= '0;
			wbSlot <= '0;
		end else begin
			if (issueGo) busy[headNo] <= 1'b1;
			if (complValid) busy[complNo] <= 1'b0;
			wbSlot <= (wbSlot >> 1) | (issueGo ? slotMask : '0);
		end
	end

	// Registered issue outputs
	always_ff @(posedge clock) begin
		if (reset) begin
			issueValid <= 1'b0;
			rawHazard  <= 1'b0;
			warHazard  <= 1'b0;
			wawHazard  <= 1'b0;
		end else begin
			issueValid <= issueGo;
			rawHazard  <= pending & raw;
			warHazard  <= pending & war;
			wawHazard  <= pending & waw;
		end
	end

	always_ff @(posedge clock) begin
		issueNo    <= headNo;
		issueIsVec <= head.isVec;
	end

	ringBuffCtrl ringCtrl (
		.clock   (clock),
		.reset   (reset),
		.alloc   (alloc),
		.issue   (issueGo),
		.retire  (retire),
		.allocNo (allocNo),
		.issueNo (headNo),
		.full    (full),
		.pending (pending)
	);

	// Pipes only ever return numbers that are in flight
	complOnlyBusy: assert property (@(posedge clock) disable iff (reset)
		complValid |-> busy[complNo]);

endmodule

// File: hdl/execPipe.sv
/*
 * Fixed-latency execution pipe
 * Carries issue numbers through LATENCY stages, one item per stage
 */
`timescale 1ns/100ps

module execPipe #(
	parameter int LATENCY = 2
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  inValid,
	input  tpuIssuePkg::issueNo_t inNo,
	output logic                  outValid,
	output tpuIssuePkg::issueNo_t outNo
);

	logic [LATENCY-1:0]    validSr;
	tpuIssuePkg::issueNo_t noSr [LATENCY];

	always_ff @(posedge clock) begin
		if (reset) begin
			validSr <= '0;
		end else begin
			validSr <= {validSr[LATENCY-2:0], inValid};
		end
	end

	always_ff @(posedge clock) begin
		noSr[0] <= inNo;
		for (int k = 1; k < LATENCY; k++) begin
			noSr[k] <= noSr[k-1];
		end
	end

	assign outValid = validSr[LATENCY-1];
	assign outNo    = noSr[LATENCY-1];

	exactLatency: assert property (@(posedge clock) disable iff (reset)
		inValid |-> ##LATENCY (outValid && outNo == $past(inNo, LATENCY)));

endmodule

// File: hdl/retireUnit.sv
/*
 * Retire unit
 * Merges pipe completions and retires table slots in program order
 */
`timescale 1ns/100ps

module retireUnit (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  sValid,
	input  logic                  vValid,
	input  tpuIssuePkg::issueNo_t sNo,
	input  tpuIssuePkg::issueNo_t vNo,
	output logic                  complValid,
	output tpuIssuePkg::issueNo_t complNo,
	output logic                  retireValid,
	output tpuIssuePkg::issueNo_t retireNo
);

	logic [tpuIssuePkg::DEPTH_BUFF-1:0] done;
	tpuIssuePkg::issueNo_t              retPtr;
	logic                               retireNow;

	assign complValid = sValid | vValid;
	assign complNo    = vValid ? vNo : sNo;

	// Completion arriving this cycle counts as done
	assign retireNow = done[retPtr] | (complValid & (complNo == retPtr));

	always_ff @(posedge clock) begin
		if (reset) begin
			done        <= '0;
			retPtr      <= '0;
			retireValid <= 1'b0;
		end else begin
			if (complValid) done[complNo] <= 1'b1;
			if (retireNow) begin
				done[retPtr] <= 1'b0;
				retPtr       <= retPtr + 1'b1;
			end
			retireValid <= retireNow;
		end
	end

	always_ff @(posedge clock) begin
		retireNo <= retPtr;
	end

	noWbCollision: assert property (@(posedge clock) disable iff (reset) !(sValid && vValid));
	singleCompletion: assert property (@(posedge clock) disable iff (reset)
		complValid |-> !done[complNo]);

endmodule

// File: hdl/tpuIssue.sv
/*
 * Tensor-processor issue stage, top level
 * Decode, hazard check, scalar and vector pipes and in-order retire
 */
`timescale 1ns/100ps

module tpuIssue (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    instrValid,
	input  tpuIssuePkg::instrWord_t instrWord,
	output logic                    instrReady,
	output logic                    issueValid,
	output tpuIssuePkg::issueNo_t   issueNo,
	output logic                    issueIsVec,
	output logic                    rawHazard,
	output logic                    warHazard,
	output logic                    wawHazard,
	output logic                    retireValid,
	output tpuIssuePkg::issueNo_t   retireNo
);

	decodedIf decBus ();

	logic                  sDone;
	logic                  vDone;
	tpuIssuePkg::issueNo_t sDoneNo;
	tpuIssuePkg::issueNo_t vDoneNo;
	logic                  complValid;
	tpuIssuePkg::issueNo_t complNo;

	instrDecode decode (
		.clock      (clock),
		.reset      (reset),
		.instrValid (instrValid),
		.instrWord  (instrWord),
		.instrReady (instrReady),
		.dec        (decBus.source)
	);

	hazardCheck hazard (
		.clock      (clock),
		.reset      (reset),
		.dec        (decBus.sink),
		.complValid (complValid),
		.complNo    (complNo),
		.retire     (retireValid),
		.issueValid (issueValid),
		.issueNo    (issueNo),
		.issueIsVec (issueIsVec),
		.rawHazard  (rawHazard),
		.warHazard  (warHazard),
		.wawHazard  (wawHazard)
	);

	////////////////////////////////////////
	// Execution pipes, selected by vector flag
	execPipe #(.LATENCY(tpuIssuePkg::LAT_SCALAR)) scalarPipe (
		.clock    (clock),
		.reset    (reset),
		.inValid  (issueValid & ~issueIsVec),
		.inNo     (issueNo),
		.outValid (sDone),
		.outNo    (sDoneNo)
	);

	execPipe #(.LATENCY(tpuIssuePkg::LAT_VECTOR)) vectorPipe (
		.clock    (clock),
		.reset    (reset),
		.inValid  (issueValid & issueIsVec),
		.inNo     (issueNo),
		.outValid (vDone),
		.outNo    (vDoneNo)
	);

	retireUnit retire (
		.clock       (clock),
		.reset       (reset),
		.sValid      (sDone),
		.vValid      (vDone),
		.sNo         (sDoneNo),
		.vNo         (vDoneNo),
		.complValid  (complValid),
		.complNo     (complNo),
		.retireValid (retireValid),
		.retireNo    (retireNo)
	);

endmodule

// File: tests/tpuIssueCases.svh
/*
 * Issue stage test cases
 * Producer and consumer words with the hazard class the pair should raise
 */
`ifndef TPU_ISSUE_CASES_SVH
`define TPU_ISSUE_CASES_SVH

// Expected flags as {waw, war, raw}
localparam logic [2:0] classNone = 3'b000;
localparam logic [2:0] classRaw  = 3'b001;
localparam logic [2:0] classWar  = 3'b010;
localparam logic [2:0] classWaw  = 3'b100;

// Valid flags ordered dst, src1, src2, src3
function automatic logic [31:0] makeWord(input logic isVec, input logic [3:0] valids,
		input logic [4:0] dst, input logic [4:0] src1, input logic [4:0] src2,
		input logic [4:0] src3);
	return {isVec, valids, 2'b00, dst, src1, src2, src3, 5'b00000};
endfunction

typedef struct packed {
	logic [31:0]     producer;
	logic [31:0]     consumer;
	logic [2:0]      hazClass;
	logic [8*20-1:0] name;
} caseRow_t;

localparam int numCases = 7;

localparam caseRow_t caseTab [numCases] = '{
	'{makeWord(0, 4'b1100, 3, 1, 0, 0), makeWord(0, 4'b1100, 4, 3, 0, 0), classRaw, "raw scalar"},
	'{makeWord(0, 4'b1100, 6, 5, 0, 0), makeWord(0, 4'b1100, 5, 7, 0, 0), classWar, "war scalar"},
	'{makeWord(1, 4'b1100, 8, 9, 0, 0), makeWord(1, 4'b1100, 8, 10, 0, 0), classWaw, "waw vector"},
	'{makeWord(1, 4'b1100, 2, 12, 0, 0), makeWord(1, 4'b1001, 11, 0, 0, 2), classRaw,
		"raw vector src3"},
	'{makeWord(0, 4'b1100, 7, 1, 0, 0), makeWord(1, 4'b1110, 7, 7, 7, 0), classNone,
		"none bank split"},
	'{makeWord(0, 4'b0110, 9, 9, 9, 0), makeWord(0, 4'b0100, 9, 9, 0, 0), classNone,
		"none invalid fields"},
	'{makeWord(1, 4'b1111, 1, 2, 3, 4), makeWord(0, 4'b1111, 5, 6, 7, 8), classNone,
		"none vector scalar"}
};

`endif

// File: tests/tpuIssueTb.sv
/*
 * Issue stage testbench
 * Table-driven hazard pairs, back-pressure and a random stream,
 * checking issue and retire order against program order
 */
`timescale 1ns/100ps

module tpuIssueTb;

	`include "tpuIssueCases.svh"

	localparam int timeoutCycles = 200;
	localparam int driveDelay    = 10;

	logic                    clock;
	logic                    reset;
	logic                    instrValid;
	tpuIssuePkg::instrWord_t instrWord;
	logic                    instrReady;
	logic                    issueValid;
	tpuIssuePkg::issueNo_t   issueNo;
	logic                    issueIsVec;
	logic                    rawHazard;
	logic                    warHazard;
	logic                    wawHazard;
	logic                    retireValid;
	tpuIssuePkg::issueNo_t   retireNo;

	integer      seed;
	int          cycle;
	int          nextNo;       // Program order slot of the next word
	int          baseNo;
	int          testErrors;
	int          passCount;
	int          failCount;
	logic        readyLowSeen;
	logic [2:0]  seenFlags;    // {waw, war, raw}
	logic [31:0] sentWords [$];
	int          issueNoQ [$];
	bit          issueVecQ [$];
	int          issueCycQ [$];
	int          retireNoQ [$];
	int          retireCycQ [$];

	tpuIssue UUT (
		.clock       (clock),
		.reset       (reset),
		.instrValid  (instrValid),
		.instrWord   (instrWord),
		.instrReady  (instrReady),
		.issueValid  (issueValid),
		.issueNo     (issueNo),
		.issueIsVec  (issueIsVec),
		.rawHazard   (rawHazard),
		.warHazard   (warHazard),
		.wawHazard   (wawHazard),
		.retireValid (retireValid),
		.retireNo    (retireNo)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Outputs sampled mid-cycle
	always @(negedge clock) begin
		cycle = cycle + 1;
		if (!reset) begin
			if (issueValid) begin
				issueNoQ.push_back(int'(issueNo));
				issueVecQ.push_back(issueIsVec);
				issueCycQ.push_back(cycle);
			end
			if (retireValid) begin
				retireNoQ.push_back(int'(retireNo));
				retireCycQ.push_back(cycle);
			end
			if (!instrReady) readyLowSeen = 1'b1; // Table and decode register both full
			seenFlags = seenFlags | {wawHazard, warHazard, rawHazard};
		end
	end

	////////////////////////////////////////
	// Helpers

	task automatic reportMismatch(input string sig, input int expVal, input int actVal);
		$display("FAIL %s expected 0x%0h got 0x%0h", sig, expVal, actVal);
		testErrors++;
	endtask

	task automatic startTest();
		sentWords.delete();
		issueNoQ.delete();
		issueVecQ.delete();
		issueCycQ.delete();
		retireNoQ.delete();
		retireCycQ.delete();
		seenFlags    = 3'b000;
		readyLowSeen = 1'b0;
		testErrors   = 0;
		baseNo       = nextNo;
	endtask

	task automatic finishTest(input string name);
		if (testErrors == 0) begin
			passCount++;
			$display("test %-20s ok", name);
		end else begin
			failCount++;
			$display("test %-20s failed with %0d errors", name, testErrors);
		end
	endtask

	// Entered and left driveDelay after a rising edge
	task automatic sendWord(input logic [31:0] word);
		int waited;
		waited     = 0;
		instrValid = 1'b1;
		instrWord  = word;
		while (!instrReady && waited < timeoutCycles) begin
			@(posedge clock);
			#driveDelay;
			waited++;
		end
		if (instrReady) begin
			@(posedge clock); // Transfer edge
			#driveDelay;
			sentWords.push_back(word);
			nextNo = (nextNo + 1) % tpuIssuePkg::DEPTH_BUFF;
		end else begin
			$display("Timed out after %0d cycles waiting for instrReady", waited);
			testErrors++;
		end
		instrValid = 1'b0;
	endtask

	task automatic waitRetired(input int count);
		int waited;
		waited = 0;
		while (retireNoQ.size() < count && waited < timeoutCycles) begin
			@(posedge clock);
			#driveDelay;
			waited++;
		end
		if (retireNoQ.size() < count) begin
			$display("Timed out waiting for %0d retirements, only %0d seen", count,
				retireNoQ.size());
			testErrors++;
		end
	endtask

	// Issue and retire both follow program order
	task automatic checkOrder();
		int n;
		int expNo;
		n = sentWords.size();
		if (issueNoQ.size() != n) begin
			reportMismatch("issueValid count", n, issueNoQ.size());
		end else begin
			for (int i = 0; i < n; i++) begin
				expNo = (baseNo + i) % tpuIssuePkg::DEPTH_BUFF;
				if (issueNoQ[i] != expNo) reportMismatch("issueNo", expNo, issueNoQ[i]);
				if (issueVecQ[i] != sentWords[i][31]) begin
					reportMismatch("issueIsVec", int'(sentWords[i][31]), int'(issueVecQ[i]));
				end
			end
		end
		if (retireNoQ.size() != n) begin
			reportMismatch("retireValid count", n, retireNoQ.size());
		end else begin
			for (int i = 0; i < n; i++) begin
				expNo = (baseNo + i) % tpuIssuePkg::DEPTH_BUFF;
				if (retireNoQ[i] != expNo) reportMismatch("retireNo", expNo, retireNoQ[i]);
			end
		end
	endtask

	task automatic runPair(input int row);
		startTest();
		sendWord(caseTab[row].producer);
		sendWord(caseTab[row].consumer);
		waitRetired(2);
		checkOrder();
		if (seenFlags != caseTab[row].hazClass) begin
			reportMismatch("hazard flags", int'(caseTab[row].hazClass), int'(seenFlags));
		end
		if (caseTab[row].hazClass != classNone && issueCycQ.size() == 2
				&& retireCycQ.size() == 2 && issueCycQ[1] < retireCycQ[0]) begin
			$display("Consumer issued in cycle %0d before producer retired in cycle %0d",
				issueCycQ[1], retireCycQ[0]);
			testErrors++;
		end
		finishTest(string'(caseTab[row].name));
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin
		logic [31:0] r;
		seed       = 32'hfd1e_11e6;
		cycle      = 0;
		nextNo     = 0;
		passCount  = 0;
		failCount  = 0;
		seenFlags  = 3'b000;
		reset      = 1'b1;
		instrValid = 1'b0;
		instrWord  = '0;

		repeat (8) @(posedge clock);
		#driveDelay;
		reset = 1'b0;

		startTest();
		if (instrReady !== 1'b1) reportMismatch("instrReady", 1, int'(instrReady));
		if (issueValid !== 1'b0) reportMismatch("issueValid", 0, int'(issueValid));
		if (retireValid !== 1'b0) reportMismatch("retireValid", 0, int'(retireValid));
		if ({wawHazard, warHazard, rawHazard} !== 3'b000) begin
			reportMismatch("hazard flags", 0, int'({wawHazard, warHazard, rawHazard}));
		end
		finishTest("reset state");

		for (int row = 0; row < numCases; row++) begin
			runPair(row);
		end

		// Same vector dst ten times, WAW serializes them
		startTest();
		for (int i = 0; i < 10; i++) begin
			sendWord(makeWord(1, 4'b1100, 20, 21, 0, 0));
		end
		waitRetired(10);
		checkOrder();
		if (!readyLowSeen) begin
			$display("instrReady never fell while the table was full");
			testErrors++;
		end
		finishTest("back-pressure");

		startTest();
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			sendWord(makeWord(r[31], r[30:27], r[24:20], r[24:20] + 5'd1, r[24:20] + 5'd2,
				r[24:20] + 5'd3));
		end
		waitRetired(40);
		checkOrder();
		finishTest("random stream");

		$display("tests %0d, passed %0d, failed %0d", passCount + failCount, passCount,
			failCount);
		if (failCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: tpuIssue.f
+incdir+tests
hdl/tpuIssuePkg.sv
hdl/decodedIf.sv
hdl/instrDecode.sv
hdl/ringBuffCtrl.sv
hdl/hazardCheck.sv
hdl/execPipe.sv
hdl/retireUnit.sv
hdl/tpuIssue.sv
tests/tpuIssueTb.sv

// File: build.sh
#!/bin/sh
# Compile the issue stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tpuIssue.f --top-module tpuIssueTb \
	--Mdir obj_dir -o tpuIssueSim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tpuIssueSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
	exit 0
fi
exit 1
